//--- hw/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Operand and result width
`define DATA_W 64

`define SHAMT_W 6

// Start edge to writeback cycle, at least 3
`define MUL_LATENCY 4

`endif

//--- hw/alu_pkg.sv
package alu_pkg;

  `include "alu_config.svh"

  typedef logic [`DATA_W-1:0]  data_t;
  typedef logic [`SHAMT_W-1:0] shamt_t;  // Low bits of operand B

  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SHL = 4'd5,
    OP_SHR = 4'd6,
    OP_SAR = 4'd7,
    OP_MUL = 4'd8   // Lane 1 only
  } alu_op_t;

  typedef enum logic [1:0] {
    FWD_REG   = 2'd0,  // Register-read value
    FWD_LANE0 = 2'd1,
    FWD_LANE1 = 2'd2
  } fwd_sel_t;

  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    MUL_RUN  = 2'd1,
    MUL_ALT  = 2'd2,  // Bus claim warning
    MUL_WB   = 2'd3
  } mul_state_t;

endpackage

//--- hw/mul_timer.sv
`timescale 1ns/1ps

`include "alu_config.svh"

module mul_timer (
  input  logic clk,
  input  logic reset,
  input  logic load,
  output logic expired
);

  localparam int CNT_W = $clog2(`MUL_LATENCY);

  logic [CNT_W-1:0] count;
  logic             running;

  always_ff @(posedge clk) begin
    if (reset) begin
      count   <= '0;
      running <= 1'b0;
    end else if (load) begin
      count   <= CNT_W'(`MUL_LATENCY - 2);  // RUN lasts MUL_LATENCY-1 cycles
      running <= 1'b1;
    end else if (running) begin
      if (count == '0) begin
        running <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  assign expired = running && (count == '0);

endmodule

//--- hw/mul_fsm.sv
`timescale 1ns/1ps

module mul_fsm (
  input  logic clk,
  input  logic reset,
  input  logic mul_start,
  input  logic timer_done,
  output logic timer_load,
  output logic mul_capture,
  output logic mul_wb,
  output logic mul_busy,
  output logic mul_alt
);
  import alu_pkg::*;

  mul_state_t state;
  mul_state_t state_next;

  // ****************************************
  // Next state
  // ****************************************

  always_comb begin
    state_next = state;
    case (state)
      MUL_IDLE: begin
        if (mul_start) begin
          state_next = MUL_RUN;
        end
      end
      MUL_RUN: begin
        if (timer_done) begin
          state_next = MUL_ALT;
        end
      end
      MUL_ALT: state_next = MUL_WB;
      MUL_WB:  state_next = MUL_IDLE;  // Start here is ignored
      default: state_next = MUL_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= MUL_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ****************************************
  // Outputs
  // ****************************************

  assign timer_load  = (state == MUL_IDLE) && mul_start;  // Also latches operands
  assign mul_capture = (state == MUL_ALT);
  assign mul_alt     = (state == MUL_ALT);  // Lane 1 slot claimed next cycle
  assign mul_wb      = (state == MUL_WB);
  assign mul_busy    = (state != MUL_IDLE);

endmodule

//--- hw/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
  input  logic           clk,
  input  logic           reset,
  input  logic           load,
  input  alu_pkg::data_t mul_a,
  input  alu_pkg::data_t mul_b,
  input  logic           mul_capture,
  output alu_pkg::data_t product
);
  import alu_pkg::*;

  data_t op_a;
  data_t op_b;

  // Operands held for the whole run
  always_ff @(posedge clk) begin
    if (load) begin
      op_a <= mul_a;
      op_b <= mul_b;
    end
  end

  // Low half only, stable in the writeback cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      product <= '0;
    end else if (mul_capture) begin
      product <= data_t'(op_a * op_b);
    end
  end

endmodule

//--- hw/alu_lane.sv
`timescale 1ns/1ps

module alu_lane #(
  parameter bit HAS_MUL = 1'b0
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              valid,
  input  alu_pkg::alu_op_t  op,
  input  alu_pkg::data_t    a,
  input  alu_pkg::data_t    b,
  input  alu_pkg::fwd_sel_t a_sel,
  input  alu_pkg::fwd_sel_t b_sel,
  input  alu_pkg::data_t    fwd_lane0,
  input  alu_pkg::data_t    fwd_lane1,
  output alu_pkg::data_t    res,
  output logic              res_valid,
  output logic              mul_start,
  output alu_pkg::data_t    mul_a,
  output alu_pkg::data_t    mul_b
);
  import alu_pkg::*;

  data_t  opnd_a;
  data_t  opnd_b;
  shamt_t shamt;
  data_t  alu_out;
  logic   alu_ok;

  // ****************************************
  // Operand bypass
  // ****************************************

  function automatic data_t pick_operand(fwd_sel_t sel, data_t reg_val,
                                         data_t bus0, data_t bus1);
    case (sel)
      FWD_LANE0: pick_operand = bus0;
      FWD_LANE1: pick_operand = bus1;
      default:   pick_operand = reg_val;
    endcase
  endfunction

  assign opnd_a = pick_operand(a_sel, a, fwd_lane0, fwd_lane1);
  assign opnd_b = pick_operand(b_sel, b, fwd_lane0, fwd_lane1);
  assign shamt  = shamt_t'(opnd_b);

  // ****************************************
  // Operation logic
  // ****************************************

  always_comb begin
    alu_ok  = 1'b1;
    alu_out = '0;
    case (op)
      OP_ADD: alu_out = opnd_a + opnd_b;
      OP_SUB: alu_out = opnd_a - opnd_b;
      OP_AND: alu_out = opnd_a & opnd_b;
      OP_OR:  alu_out = opnd_a | opnd_b;
      OP_XOR: alu_out = opnd_a ^ opnd_b;
      OP_SHL: alu_out = opnd_a << shamt;
      OP_SHR: alu_out = opnd_a >> shamt;
      OP_SAR: alu_out = $signed(opnd_a) >>> shamt;
      default: begin
        alu_ok = 1'b0;  // OP_MUL and spare codes
      end
    endcase
  end

  // Bus holds its value until the next valid result
  always_ff @(posedge clk) begin
    if (reset) begin
      res       <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= valid && alu_ok;
      if (valid && alu_ok) begin
        res <= alu_out;
      end
    end
  end

  // ****************************************
  // Multiply start
  // ****************************************

  generate
    if (HAS_MUL) begin : g_mul
      assign mul_start = valid && (op == OP_MUL);
      assign mul_a     = opnd_a;  // Bypassed operands
      assign mul_b     = opnd_b;
    end else begin : g_no_mul
      assign mul_start = 1'b0;    // OP_MUL dropped
      assign mul_a     = '0;
      assign mul_b     = '0;
    end
  endgenerate

endmodule

//--- hw/alu_cluster.sv
`timescale 1ns/1ps

module alu_cluster (
  input  logic              clk,
  input  logic              reset,
  input  logic              lane0_valid,
  input  alu_pkg::alu_op_t  lane0_op,
  input  alu_pkg::data_t    lane0_a,
  input  alu_pkg::data_t    lane0_b,
  input  alu_pkg::fwd_sel_t lane0_a_sel,
  input  alu_pkg::fwd_sel_t lane0_b_sel,
  input  logic              lane1_valid,
  input  alu_pkg::alu_op_t  lane1_op,
  input  alu_pkg::data_t    lane1_a,
  input  alu_pkg::data_t    lane1_b,
  input  alu_pkg::fwd_sel_t lane1_a_sel,
  input  alu_pkg::fwd_sel_t lane1_b_sel,
  output alu_pkg::data_t    lane0_res,
  output logic              lane0_res_valid,
  output alu_pkg::data_t    lane1_res,
  output logic              lane1_res_valid,
  output logic              mul_busy,
  output logic              mul_alt
);
  import alu_pkg::*;

  data_t lane1_alu_res;
  logic  lane1_alu_valid;
  logic  mul_start;
  data_t mul_a;
  data_t mul_b;
  logic  timer_load;
  logic  timer_done;
  logic  mul_capture;
  logic  mul_wb;
  data_t product;

  // ****************************************
  // Lanes
  // ****************************************

  alu_lane #(.HAS_MUL(1'b0)) lane0_inst (
    .clk       (clk),
    .reset     (reset),
    .valid     (lane0_valid),
    .op        (lane0_op),
    .a         (lane0_a),
    .b         (lane0_b),
    .a_sel     (lane0_a_sel),
    .b_sel     (lane0_b_sel),
    .fwd_lane0 (lane0_res),
    .fwd_lane1 (lane1_res),   // Merged bus
    .res       (lane0_res),
    .res_valid (lane0_res_valid),
    .mul_start (),
    .mul_a     (),
    .mul_b     ()
  );

  alu_lane #(.HAS_MUL(1'b1)) lane1_inst (
    .clk       (clk),
    .reset     (reset),
    .valid     (lane1_valid),
    .op        (lane1_op),
    .a         (lane1_a),
    .b         (lane1_b),
    .a_sel     (lane1_a_sel),
    .b_sel     (lane1_b_sel),
    .fwd_lane0 (lane0_res),
    .fwd_lane1 (lane1_res),
    .res       (lane1_alu_res),
    .res_valid (lane1_alu_valid),
    .mul_start (mul_start),
    .mul_a     (mul_a),
    .mul_b     (mul_b)
  );

  // ****************************************
  // Multiplier
  // ****************************************

  mul_fsm mul_fsm_inst (
    .clk         (clk),
    .reset       (reset),
    .mul_start   (mul_start),
    .timer_done  (timer_done),
    .timer_load  (timer_load),
    .mul_capture (mul_capture),
    .mul_wb      (mul_wb),
    .mul_busy    (mul_busy),
    .mul_alt     (mul_alt)
  );

  mul_timer mul_timer_inst (
    .clk     (clk),
    .reset   (reset),
    .load    (timer_load),
    .expired (timer_done)
  );

  mul_unit mul_unit_inst (
    .clk         (clk),
    .reset       (reset),
    .load        (timer_load),
    .mul_a       (mul_a),
    .mul_b       (mul_b),
    .mul_capture (mul_capture),
    .product     (product)
  );

  // Product wins the lane 1 slot
  assign lane1_res       = mul_wb ? product : lane1_alu_res;
  assign lane1_res_valid = mul_wb || lane1_alu_valid;

endmodule

//--- verif/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Reference state of the two result buses and the multiplier
data_t ref_res0;
data_t ref_res1;        // Lane 1 ALU result, product not merged
logic  ref_valid0;
logic  ref_valid1;
data_t ref_product;
logic  ref_mul_active;
int    ref_mul_rem;     // Cycles left until writeback

function automatic data_t expected_alu(alu_op_t op, data_t x, data_t y);
  int s;
  s = int'(y[`SHAMT_W-1:0]);
  case (op)
    OP_ADD:  return x + y;
    OP_SUB:  return x + ~y + 1'b1;  // Two's complement
    OP_AND:  return x & y;
    OP_OR:   return x | y;
    OP_XOR:  return x ^ y;
    OP_SHL:  return x << s;
    OP_SHR:  return x >> s;
    OP_SAR:  return (x >> s) | (x[`DATA_W-1] ? ~({`DATA_W{1'b1}} >> s) : '0);
    default: return '0;
  endcase
endfunction

function automatic data_t pick_source(fwd_sel_t sel, data_t reg_val, data_t bus0, data_t bus1);
  if (sel == FWD_LANE0) return bus0;
  if (sel == FWD_LANE1) return bus1;
  return reg_val;
endfunction

function automatic logic writeback_now();
  return ref_mul_active && (ref_mul_rem == 0);
endfunction

function automatic logic alt_expected();
  return ref_mul_active && (ref_mul_rem == 1);
endfunction

function automatic data_t bus1_value();
  return writeback_now() ? ref_product : ref_res1;
endfunction

function automatic logic valid1_value();
  return writeback_now() || ref_valid1;
endfunction

task automatic clear_model();
  ref_res0       = '0;
  ref_res1       = '0;
  ref_valid0     = 1'b0;
  ref_valid1     = 1'b0;
  ref_product    = '0;
  ref_mul_active = 1'b0;
  ref_mul_rem    = 0;
endtask

// One clock edge, from the inputs as they stand at the edge
task automatic advance_model();
  data_t bus0;
  data_t bus1;
  data_t a0;
  data_t b0;
  data_t a1;
  data_t b1;
  logic  alu0;
  logic  alu1;
  bus0 = ref_res0;
  bus1 = bus1_value();
  a0   = pick_source(lane0_a_sel, lane0_a, bus0, bus1);
  b0   = pick_source(lane0_b_sel, lane0_b, bus0, bus1);
  a1   = pick_source(lane1_a_sel, lane1_a, bus0, bus1);
  b1   = pick_source(lane1_b_sel, lane1_b, bus0, bus1);
  alu0 = lane0_valid && (lane0_op != OP_MUL);
  alu1 = lane1_valid && (lane1_op != OP_MUL);
  ref_valid0 = alu0;
  ref_valid1 = alu1;
  if (alu0) ref_res0 = expected_alu(lane0_op, a0, b0);
  if (alu1) ref_res1 = expected_alu(lane1_op, a1, b1);
  if (ref_mul_active) begin
    if (ref_mul_rem == 0) ref_mul_active = 1'b0;
    else ref_mul_rem = ref_mul_rem - 1;
  end else if (lane1_valid && (lane1_op == OP_MUL)) begin
    ref_mul_active = 1'b1;
    ref_mul_rem    = `MUL_LATENCY;
    ref_product    = a1 * b1;  // Low half
  end
endtask

`endif

//--- verif/alu_cluster_tb.sv
`timescale 1ns/1ps

`include "alu_config.svh"

module alu_cluster_tb;
  import alu_pkg::*;

  localparam int BUSY_TIMEOUT = 4 * `MUL_LATENCY + 8;

  logic     clk;
  logic     reset;
  logic     lane0_valid;
  alu_op_t  lane0_op;
  data_t    lane0_a;
  data_t    lane0_b;
  fwd_sel_t lane0_a_sel;
  fwd_sel_t lane0_b_sel;
  logic     lane1_valid;
  alu_op_t  lane1_op;
  data_t    lane1_a;
  data_t    lane1_b;
  fwd_sel_t lane1_a_sel;
  fwd_sel_t lane1_b_sel;
  data_t    lane0_res;
  logic     lane0_res_valid;
  data_t    lane1_res;
  logic     lane1_res_valid;
  logic     mul_busy;
  logic     mul_alt;

  integer seed;
  int     checks;
  int     errors;
  int     test_errors;  // Error count at the start of a test

  `include "alu_ref_model.svh"

  alu_cluster alu_cluster_inst (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic compare(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // ****************************************
  // Cycle and stimulus helpers
  // ****************************************

  task automatic run_cycle();
    @(posedge clk);
    advance_model();
    #1;
    compare("lane0_res", lane0_res, ref_res0);
    compare("lane0_res_valid", data_t'(lane0_res_valid), data_t'(ref_valid0));
    compare("lane1_res", lane1_res, bus1_value());
    compare("lane1_res_valid", data_t'(lane1_res_valid), data_t'(valid1_value()));
    compare("mul_busy", data_t'(mul_busy), data_t'(ref_mul_active));
    compare("mul_alt", data_t'(mul_alt), data_t'(alt_expected()));
  endtask

  task automatic drive_idle();
    lane0_valid = 1'b0;
    lane0_op    = OP_ADD;
    lane0_a     = '0;
    lane0_b     = '0;
    lane0_a_sel = FWD_REG;
    lane0_b_sel = FWD_REG;
    lane1_valid = 1'b0;
    lane1_op    = OP_ADD;
    lane1_a     = '0;
    lane1_b     = '0;
    lane1_a_sel = FWD_REG;
    lane1_b_sel = FWD_REG;
  endtask

  function automatic fwd_sel_t random_sel();
    return fwd_sel_t'(2'($unsigned($random(seed)) % 3));
  endfunction

  task automatic drive_random(input bit use_fwd, input bit allow_mul, input bit full_rate);
    lane0_valid = full_rate ? 1'b1 : 1'($random(seed));
    lane1_valid = full_rate ? 1'b1 : 1'($random(seed));
    lane0_op    = alu_op_t'(4'($random(seed)) & 4'h7);
    lane1_op    = alu_op_t'(4'($random(seed)) & 4'h7);
    lane0_a     = {$random(seed), $random(seed)};
    lane0_b     = {$random(seed), $random(seed)};
    lane1_a     = {$random(seed), $random(seed)};
    lane1_b     = {$random(seed), $random(seed)};
    lane0_a_sel = use_fwd ? random_sel() : FWD_REG;
    lane0_b_sel = use_fwd ? random_sel() : FWD_REG;
    lane1_a_sel = use_fwd ? random_sel() : FWD_REG;
    lane1_b_sel = use_fwd ? random_sel() : FWD_REG;
    if (allow_mul && (3'($random(seed)) == 3'd0)) lane1_op = OP_MUL;
    if (use_fwd && writeback_now()) begin
      lane0_valid = 1'b1;
      lane0_a_sel = FWD_LANE1;  // Fresh product
    end
    if (alt_expected()) lane1_valid = 1'b0;  // Slot taken by the product
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    drive_idle();
    while (mul_busy && (n < BUSY_TIMEOUT)) begin
      run_cycle();
      n++;
    end
    if (mul_busy) begin
      errors++;
      $display("Timeout: multiplier still busy after %0d cycles", n);
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d %s: %0d mismatches", num, name, errors - test_errors);
    test_errors = errors;
  endtask

  // ****************************************
  // Test sequence
  // ****************************************

  initial begin
    int    k;
    data_t ma;
    data_t mb;
    seed        = 32'h2adb0b14;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    reset       = 1'b1;
    drive_idle();
    clear_model();
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;

    repeat (3) run_cycle();
    report_test(1, "reset state");

    for (int i = 0; i < 200; i++) begin
      drive_random(1'b0, 1'b0, 1'b1);
      if (i % 16 == 0) begin
        lane0_op              = OP_SAR;
        lane0_a[`DATA_W-1]    = 1'b1;  // Negative value
      end
      run_cycle();
    end
    report_test(2, "register operands");

    for (int i = 0; i < 200; i++) begin
      drive_random(1'b1, 1'b0, 1'b0);
      run_cycle();
    end
    report_test(3, "bypass selects");

    drive_idle();
    lane1_valid = 1'b1;
    lane1_op    = OP_MUL;
    lane1_a     = {$random(seed), $random(seed)};
    lane1_b     = {$random(seed), $random(seed)};
    ma          = lane1_a;
    mb          = lane1_b;
    run_cycle();
    k = 0;  // Edges since the start edge
    drive_idle();
    while (mul_busy && (k <= BUSY_TIMEOUT)) begin
      compare("mul_alt", data_t'(mul_alt), data_t'(k == `MUL_LATENCY - 1));
      compare("lane1_res_valid", data_t'(lane1_res_valid), data_t'(k == `MUL_LATENCY));
      if (k == `MUL_LATENCY) compare("lane1_res", lane1_res, ma * mb);
      if (k == 2) begin
        lane1_valid = 1'b1;  // Second start while busy
        lane1_op    = OP_MUL;
      end else begin
        drive_idle();
      end
      run_cycle();
      k++;
    end
    if (mul_busy) begin
      errors++;
      $display("Timeout: multiply did not finish within %0d cycles", BUSY_TIMEOUT);
    end
    compare("mul_busy end cycle", data_t'(k), data_t'(`MUL_LATENCY + 1));
    drive_idle();
    repeat (`MUL_LATENCY + 2) run_cycle();
    report_test(4, "multiply timing");

    for (int i = 0; i < 400; i++) begin
      drive_random(1'b1, 1'b1, 1'b0);
      run_cycle();
    end
    wait_idle();
    report_test(5, "mixed stream");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+hw
+incdir+verif
hw/alu_pkg.sv
hw/mul_timer.sv
hw/mul_fsm.sv
hw/mul_unit.sv
hw/alu_lane.sv
hw/alu_cluster.sv
verif/alu_cluster_tb.sv

//--- Makefile
# Verilator build and run for the ALU cluster

VERILATOR  ?= verilator
TOP        ?= alu_cluster_tb
RTL_TOP    ?= alu_cluster
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= -Wall
FAIL_MSG   ?= test failed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation OK"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
